/* logic/cpu_params.sv */
package cpu_params;

    // address and data width of the core
    localparam int unsigned XLEN = 32;
    localparam int unsigned WORD_BYTES = XLEN / 8;

    // instructions per fetch block, kept at one word
    localparam int unsigned IF_WIDTH = 1;
    localparam int unsigned IF_BLK_SIZE = IF_WIDTH * WORD_BYTES;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // fetch queue sizing, depth must be a power of two
    localparam int unsigned FETCH_QUEUE_DEPTH = 4;
    localparam int unsigned FQ_PTR_W = $clog2(FETCH_QUEUE_DEPTH);
    localparam int unsigned FQ_CNT_W = FQ_PTR_W + 1;

endpackage

/* logic/rv_inst_pkg.sv */
package rv_inst_pkg;

    localparam int unsigned ILEN = 32;
    localparam int unsigned CTRL_W = 2;

    // one instruction word, seen either raw or split into R-type fields
    typedef union packed {
        logic [ILEN-1:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } f;
    } rv_inst_t;

    // major opcodes of the control-flow instructions
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // control kind tagged on each fetched word
    localparam logic [CTRL_W-1:0] CTRL_NONE = 2'd0;
    localparam logic [CTRL_W-1:0] CTRL_BRANCH = 2'd1;
    localparam logic [CTRL_W-1:0] CTRL_JAL = 2'd2;
    localparam logic [CTRL_W-1:0] CTRL_JALR = 2'd3;

endpackage

/* logic/inst_predecode.sv */
module inst_predecode
    import rv_inst_pkg::*;
(
    input  logic [ILEN-1:0]   inst,
    output logic [CTRL_W-1:0] ctrl
);

    rv_inst_t word;

    assign word.raw = inst;

    // the control kind follows from the major opcode alone
    always_comb begin
        case (word.f.opcode)
            OPC_BRANCH: begin
                ctrl = CTRL_BRANCH;
            end
            OPC_JAL: begin
                ctrl = CTRL_JAL;
            end
            OPC_JALR: begin
                ctrl = CTRL_JALR;
            end
            default: begin
                ctrl = CTRL_NONE;
            end
        endcase
    end

endmodule

/* logic/if1_stage.sv */
module if1_stage
    import cpu_params::*;
(
    input  logic                  clk,
    input  logic                  prev_rst,

    input  logic                  flush,
    input  logic [XLEN-1:0]       pc_next,

    output logic                  nxt_valid,
    input  logic                  nxt_ready,
    output logic [XLEN-1:0]       pc,
    output logic [XLEN-1:0]       inst,

    output logic [XLEN-1:0]       imem_addr,
    output logic [WORD_BYTES-1:0] imem_rmask,
    input  logic [XLEN-1:0]       imem_rdata,
    input  logic                  imem_resp
);

    // state is idle (neither flag), waiting (req_q) or holding (valid_q)
    logic            req_q;
    logic            valid_q;
    // outstanding request was issued before a flush
    logic            stale_q;
    // pc_q is a fetched address, so the next fetch may follow on sequentially
    logic            seq_q;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic [XLEN-1:0] redir_q;

    logic            idle;
    logic [XLEN-1:0] fetch_pc;

    assign idle = !req_q && !valid_q;

    // a flush in the issue cycle already shows up on pc_next
    assign fetch_pc = (seq_q || flush) ? pc_next : redir_q;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            req_q   <= 1'b0;
            valid_q <= 1'b0;
            stale_q <= 1'b0;
            seq_q   <= 1'b0;
        end else if (idle) begin
            req_q <= 1'b1;
            seq_q <= 1'b1;
        end else begin
            if (flush) begin
                seq_q <= 1'b0;
            end
            if (req_q) begin
                if (imem_resp) begin
                    req_q   <= 1'b0;
                    stale_q <= 1'b0;
                    // drop words fetched for a path that was flushed
                    valid_q <= !(stale_q || flush);
                end else if (flush) begin
                    stale_q <= 1'b1;
                end
            end
            if (valid_q && (flush || nxt_ready)) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // reset vector or redirect target, used if seq_q is low at issue
        if (prev_rst || flush) begin
            redir_q <= pc_next;
        end
        if (idle) begin
            pc_q <= fetch_pc;
        end
        if (req_q && imem_resp) begin
            inst_q <= imem_rdata;
        end
    end

    assign imem_addr  = {pc_q[XLEN-1:2], 2'b00};
    assign imem_rmask = req_q ? '1 : '0;

    assign nxt_valid = valid_q;
    assign pc        = pc_q;
    assign inst      = inst_q;

endmodule

/* logic/frontend_top.sv */
module frontend_top
    import cpu_params::*;
(
    input  logic                  clk,
    input  logic                  prev_rst,

    input  logic                  backend_flush,
    input  logic [XLEN-1:0]       backend_redirect_pc,

    output logic                  nxt_valid,
    input  logic                  nxt_ready,
    output logic [XLEN-1:0]       pc,
    output logic [XLEN-1:0]       inst,

    output logic [XLEN-1:0]       imem_addr,
    output logic [WORD_BYTES-1:0] imem_rmask,
    input  logic [XLEN-1:0]       imem_rdata,
    input  logic                  imem_resp
);

    localparam logic [XLEN-1:0] BLK_STEP = XLEN'(IF_BLK_SIZE);

    logic [XLEN-1:0] pc_next;

    // next fetch block start, aligned down to the block size
    always_comb begin
        if (prev_rst) begin
            pc_next = RESET_PC;
        end else if (backend_flush) begin
            pc_next = backend_redirect_pc;
        end else begin
            pc_next = (pc + BLK_STEP) & ~(BLK_STEP - 1'b1);
        end
    end

    if1_stage u_if1_stage (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .flush      (backend_flush),
        .pc_next    (pc_next),
        .nxt_valid  (nxt_valid),
        .nxt_ready  (nxt_ready),
        .pc         (pc),
        .inst       (inst),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp)
    );

endmodule

/* logic/fetch_queue.sv */
module fetch_queue
    import cpu_params::*;
    import rv_inst_pkg::*;
(
    input  logic              clk,
    input  logic              prev_rst,
    input  logic              flush,

    input  logic              enq_valid,
    output logic              enq_ready,
    input  logic [XLEN-1:0]   enq_pc,
    input  logic [XLEN-1:0]   enq_inst,
    input  logic [CTRL_W-1:0] enq_ctrl,

    output logic              deq_valid,
    input  logic              deq_ready,
    output logic [XLEN-1:0]   deq_pc,
    output logic [XLEN-1:0]   deq_inst,
    output logic [CTRL_W-1:0] deq_ctrl
);

    logic [XLEN-1:0]   pc_mem   [FETCH_QUEUE_DEPTH];
    logic [XLEN-1:0]   inst_mem [FETCH_QUEUE_DEPTH];
    logic [CTRL_W-1:0] ctrl_mem [FETCH_QUEUE_DEPTH];

    logic [FQ_PTR_W-1:0] wr_ptr_q;
    logic [FQ_PTR_W-1:0] rd_ptr_q;
    logic [FQ_CNT_W-1:0] count_q;

    logic push;
    logic pop;

    assign enq_ready = (count_q != FQ_CNT_W'(FETCH_QUEUE_DEPTH));
    assign deq_valid = (count_q != '0);

    assign push = enq_valid && enq_ready;
    assign pop  = deq_valid && deq_ready;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (prev_rst || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + FQ_CNT_W'(push) - FQ_CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]   <= enq_pc;
            inst_mem[wr_ptr_q] <= enq_inst;
            ctrl_mem[wr_ptr_q] <= enq_ctrl;
        end
    end

    assign deq_pc   = pc_mem[rd_ptr_q];
    assign deq_inst = inst_mem[rd_ptr_q];
    assign deq_ctrl = ctrl_mem[rd_ptr_q];

endmodule

/* logic/cpu_frontend.sv */
module cpu_frontend
    import cpu_params::*;
    import rv_inst_pkg::*;
(
    input  logic                  clk,
    input  logic                  prev_rst,

    input  logic                  backend_flush,
    input  logic [XLEN-1:0]       backend_redirect_pc,

    output logic                  deq_valid,
    input  logic                  deq_ready,
    output logic [XLEN-1:0]       deq_pc,
    output logic [XLEN-1:0]       deq_inst,
    output logic [CTRL_W-1:0]     deq_ctrl,

    output logic [XLEN-1:0]       imem_addr,
    output logic [WORD_BYTES-1:0] imem_rmask,
    input  logic [XLEN-1:0]       imem_rdata,
    input  logic                  imem_resp
);

    // fetch stage output toward the queue
    logic              fe_valid;
    logic              fe_ready;
    logic [XLEN-1:0]   fe_pc;
    logic [XLEN-1:0]   fe_inst;
    logic [CTRL_W-1:0] fe_ctrl;

    frontend_top u_frontend_top (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .nxt_valid           (fe_valid),
        .nxt_ready           (fe_ready),
        .pc                  (fe_pc),
        .inst                (fe_inst),
        .imem_addr           (imem_addr),
        .imem_rmask          (imem_rmask),
        .imem_rdata          (imem_rdata),
        .imem_resp           (imem_resp)
    );

    // tags the held word so each entry enters the queue already classified
    inst_predecode u_inst_predecode (
        .inst (fe_inst),
        .ctrl (fe_ctrl)
    );

    fetch_queue u_fetch_queue (
        .clk       (clk),
        .prev_rst  (prev_rst),
        .flush     (backend_flush),
        .enq_valid (fe_valid),
        .enq_ready (fe_ready),
        .enq_pc    (fe_pc),
        .enq_inst  (fe_inst),
        .enq_ctrl  (fe_ctrl),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready),
        .deq_pc    (deq_pc),
        .deq_inst  (deq_inst),
        .deq_ctrl  (deq_ctrl)
    );

endmodule

/* verif/imem_model.sv */
module imem_model
    import cpu_params::*;
(
    input  logic                  clk,
    input  logic                  prev_rst,
    input  logic [XLEN-1:0]       imem_addr,
    input  logic [WORD_BYTES-1:0] imem_rmask,
    output logic [XLEN-1:0]       imem_rdata,
    output logic                  imem_resp
);

    logic       busy;
    logic [1:0] wait_cnt;

    // opcode picked by address bits 3:2, the address fills the upper bits
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        logic [6:0] opc;
        case (addr[3:2])
            2'd0: opc = 7'b0010011;
            2'd1: opc = 7'b1100011;
            2'd2: opc = 7'b1101111;
            default: opc = 7'b1100111;
        endcase
        return {addr[XLEN-1:7], opc};
    endfunction

    initial begin
        imem_resp  = 1'b0;
        imem_rdata = '0;
    end

    always @(posedge clk) begin : resp_gen
        int unsigned delay;
        if (prev_rst) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            imem_resp <= 1'b0;
        end else begin
            imem_resp <= 1'b0;
            if (imem_resp) begin
                // mask is still up in the response cycle
                busy <= 1'b0;
            end else if (busy) begin
                if (wait_cnt == 2'd0) begin
                    imem_resp  <= 1'b1;
                    imem_rdata <= word_at(imem_addr);
                    busy       <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end else if (imem_rmask != '0) begin
                delay = $urandom % 4;
                if (delay == 0) begin
                    imem_resp  <= 1'b1;
                    imem_rdata <= word_at(imem_addr);
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= 2'(delay - 1);
                end
            end
        end
    end

endmodule

/* verif/frontend_tb.sv */
module frontend_tb
    import cpu_params::*;
    import rv_inst_pkg::*;
();

    localparam int NUM_ROWS = 10;
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_ALT = 1;
    localparam int RDY_RANDOM = 2;
    localparam int FL_NONE = 0;
    localparam int FL_NOW = 1;
    localparam int FL_BUSY = 2;
    localparam int FL_TWICE = 3;

    logic                  clk;
    logic                  prev_rst;
    logic                  backend_flush;
    logic [XLEN-1:0]       backend_redirect_pc;
    logic                  deq_ready;
    logic                  deq_valid;
    logic [XLEN-1:0]       deq_pc;
    logic [XLEN-1:0]       deq_inst;
    logic [CTRL_W-1:0]     deq_ctrl;
    logic [XLEN-1:0]       imem_addr;
    logic [WORD_BYTES-1:0] imem_rmask;
    logic [XLEN-1:0]       imem_rdata;
    logic                  imem_resp;

    // one stimulus phase per row
    string           row_name  [NUM_ROWS];
    int              row_count [NUM_ROWS];
    int              row_rdy   [NUM_ROWS];
    int              row_pre   [NUM_ROWS];
    int              row_flush [NUM_ROWS];
    logic [XLEN-1:0] row_decoy [NUM_ROWS];
    logic [XLEN-1:0] row_redir [NUM_ROWS];
    logic [XLEN-1:0] row_start [NUM_ROWS];

    string           cur_name = "reset";
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] held_addr;
    logic            req_open;
    logic            resp_prev;
    int              stall_left;
    int              n_checked = 0;
    int              value_errs = 0;
    int              proto_errs = 0;
    int              timeouts = 0;
    logic            timed_out = 1'b0;

    cpu_frontend u_cpu_frontend (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .deq_valid           (deq_valid),
        .deq_ready           (deq_ready),
        .deq_pc              (deq_pc),
        .deq_inst            (deq_inst),
        .deq_ctrl            (deq_ctrl),
        .imem_addr           (imem_addr),
        .imem_rmask          (imem_rmask),
        .imem_rdata          (imem_rdata),
        .imem_resp           (imem_resp)
    );

    imem_model u_imem_model (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // opcode from address bits 3:2 (OP-IMM, BRANCH, JAL, JALR) with the address above
    function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] addr);
        logic [6:0] opc [4];
        opc = '{7'b0010011, 7'b1100011, 7'b1101111, 7'b1100111};
        return {addr[XLEN-1:7], opc[addr[3:2]]};
    endfunction

    // control kind of the major opcode
    function automatic logic [CTRL_W-1:0] expected_ctrl(input logic [XLEN-1:0] word);
        case (word[6:0])
            7'b1100011: return CTRL_BRANCH;
            7'b1101111: return CTRL_JAL;
            7'b1100111: return CTRL_JALR;
            default: return CTRL_NONE;
        endcase
    endfunction

    task automatic set_row(input int i, input string name, input int count, input int rdy,
                           input int pre, input int fl, input logic [XLEN-1:0] decoy,
                           input logic [XLEN-1:0] redir, input logic [XLEN-1:0] start);
        row_name[i]  = name;
        row_count[i] = count;
        row_rdy[i]   = rdy;
        row_pre[i]   = pre;
        row_flush[i] = fl;
        row_decoy[i] = decoy;
        row_redir[i] = redir;
        row_start[i] = start;
    endtask

    // every cycle of stimulus starts 1 unit after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
        backend_flush = 1'b0;
    endtask

    task automatic check_entry();
        logic [XLEN-1:0] word;
        word = expected_word(exp_pc);
        assert (deq_pc == exp_pc) else begin
            value_errs++;
            $display("CHECK FAILED %s deq_pc: expected %h actual %h", cur_name, exp_pc, deq_pc);
        end
        assert (deq_inst == word) else begin
            value_errs++;
            $display("CHECK FAILED %s deq_inst: expected %h actual %h", cur_name, word,
                     deq_inst);
        end
        assert (deq_ctrl == expected_ctrl(word)) else begin
            value_errs++;
            $display("CHECK FAILED %s deq_ctrl: expected %0d actual %0d", cur_name,
                     expected_ctrl(word), deq_ctrl);
        end
        exp_pc = exp_pc + 32'd4;
        n_checked++;
    endtask

    task automatic flush_once(input logic [XLEN-1:0] pc);
        tick();
        backend_flush       = 1'b1;
        backend_redirect_pc = pc;
        deq_ready           = 1'b0;
    endtask

    // drain the queue until a memory request is in flight, then flush into it
    task automatic flush_when_busy(input logic [XLEN-1:0] pc);
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            tick();
            if (imem_rmask != '0 && !imem_resp) begin
                backend_flush       = 1'b1;
                backend_redirect_pc = pc;
                deq_ready           = 1'b0;
                done                = 1'b1;
            end else begin
                deq_ready = 1'b1;
                @(negedge clk);
                if (deq_valid) begin
                    check_entry();
                end
                waited++;
                if (waited > 100) begin
                    timed_out = 1'b1;
                    timeouts++;
                    $display("%s: no memory request went out within 100 cycles", cur_name);
                end
            end
        end
    endtask

    task automatic consume(input int r);
        int got;
        int cycles;
        int limit;
        got = 0;
        cycles = 0;
        limit = row_count[r] * 40 + 100;
        while (got < row_count[r] && !timed_out) begin
            tick();
            case (row_rdy[r])
                RDY_ALWAYS: deq_ready = 1'b1;
                RDY_ALT: deq_ready = cycles[0];
                default: begin
                    if (stall_left > 0) begin
                        deq_ready = 1'b0;
                        stall_left--;
                    end else if (($urandom % 4) == 0) begin
                        deq_ready  = 1'b0;
                        stall_left = 4 + ($urandom % 12);
                    end else begin
                        deq_ready = 1'b1;
                    end
                end
            endcase
            @(negedge clk);
            if (deq_valid && deq_ready) begin
                check_entry();
                got++;
            end
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
                timeouts++;
                $display("%s: only %0d of %0d entries arrived within %0d cycles", cur_name,
                         got, row_count[r], limit);
            end
        end
    endtask

    task automatic run_row(input int r);
        cur_name = row_name[r];
        stall_left = 0;
        repeat (row_pre[r]) begin
            tick();
            deq_ready = 1'b0;
        end
        case (row_flush[r])
            FL_NOW: flush_once(row_redir[r]);
            FL_BUSY: flush_when_busy(row_redir[r]);
            FL_TWICE: begin
                flush_once(row_decoy[r]);
                flush_once(row_redir[r]);
            end
            default: ;
        endcase
        exp_pc = row_start[r];
        consume(r);
    endtask

    // memory port must hold address and mask from the mask rise until the response
    always @(negedge clk) begin
        if (prev_rst) begin
            req_open  = 1'b0;
            resp_prev = 1'b0;
        end else begin
            if (resp_prev) begin
                assert (imem_rmask == '0) else begin
                    proto_errs++;
                    $display("%s: memory mask still raised after the response", cur_name);
                end
            end
            if (imem_rmask != '0) begin
                assert (imem_rmask == {WORD_BYTES{1'b1}}) else begin
                    proto_errs++;
                    $display("CHECK FAILED %s imem_rmask: expected %h actual %h", cur_name,
                             {WORD_BYTES{1'b1}}, imem_rmask);
                end
                if (req_open) begin
                    assert (imem_addr == held_addr) else begin
                        proto_errs++;
                        $display("CHECK FAILED %s imem_addr: expected %h actual %h", cur_name,
                                 held_addr, imem_addr);
                    end
                end else begin
                    req_open  = 1'b1;
                    held_addr = imem_addr;
                end
            end
            if (imem_resp) begin
                // the request stays up through the response cycle
                assert (imem_rmask == {WORD_BYTES{1'b1}}) else begin
                    proto_errs++;
                    $display("CHECK FAILED %s imem_rmask at response: expected %h actual %h",
                             cur_name, {WORD_BYTES{1'b1}}, imem_rmask);
                end
                req_open = 1'b0;
            end
            resp_prev = imem_resp;
        end
    end

    initial begin
        void'($urandom(32'hef56));
        prev_rst            = 1'b1;
        backend_flush       = 1'b0;
        backend_redirect_pc = '0;
        deq_ready           = 1'b0;
        set_row(0, "reset_stream", 6, RDY_ALWAYS, 0, FL_NONE, '0, '0, RESET_PC);
        set_row(1, "alternate_ready", 6, RDY_ALT, 0, FL_NONE, '0, '0, 32'h1eceb018);
        set_row(2, "random_stall", 12, RDY_RANDOM, 0, FL_NONE, '0, '0, 32'h1eceb030);
        set_row(3, "full_queue_hold", 8, RDY_ALWAYS, 20, FL_NONE, '0, '0, 32'h1eceb060);
        set_row(4, "flush_redirect", 6, RDY_ALWAYS, 0, FL_NOW, '0, 32'h00400100,
                32'h00400100);
        set_row(5, "flush_in_flight", 6, RDY_RANDOM, 0, FL_BUSY, '0, 32'h00801000,
                32'h00801000);
        set_row(6, "flush_twice", 6, RDY_ALT, 0, FL_TWICE, 32'h00a00000, 32'h00c04040,
                32'h00c04040);
        set_row(7, "flush_full", 8, RDY_RANDOM, 20, FL_NOW, '0, 32'h01020300, 32'h01020300);
        set_row(8, "flush_full_twice", 5, RDY_ALWAYS, 16, FL_TWICE, 32'h7fff0000,
                32'h00002ff0, 32'h00002ff0);
        set_row(9, "flush_in_flight_alt", 10, RDY_ALT, 0, FL_BUSY, '0, 32'h00000040,
                32'h00000040);
        repeat (8) @(posedge clk);
        #1;
        prev_rst = 1'b0;
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            run_row(r);
        end
        $display("checked %0d entries: value errors %0d, protocol errors %0d, timeouts %0d",
                 n_checked, value_errs, proto_errs, timeouts);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
logic/cpu_params.sv
logic/rv_inst_pkg.sv
logic/inst_predecode.sv
logic/if1_stage.sv
logic/frontend_top.sv
logic/fetch_queue.sv
logic/cpu_frontend.sv
verif/imem_model.sv
verif/frontend_tb.sv

/* Bender.yml */
package:
  name: cpu_frontend

sources:
  - logic/cpu_params.sv
  - logic/rv_inst_pkg.sv
  - logic/inst_predecode.sv
  - logic/if1_stage.sv
  - logic/frontend_top.sv
  - logic/fetch_queue.sv
  - logic/cpu_frontend.sv
  - target: test
    files:
      - verif/imem_model.sv
      - verif/frontend_tb.sv
